// File: hw/capture_macros.svh
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// --------------------------------------------------
// camera channels and data widths
`define CAP_NUM_CH      3
`define CAP_BYTE_W      8
`define CAP_WORD_W      32

// burst size and per channel buffering
`define CAP_BURST_LEN   8
`define CAP_FIFO_DEPTH  32
// fill count has to reach CAP_FIFO_DEPTH itself
`define CAP_CNT_W       6

// word address is {channel, bank, offset}
`define CAP_OFS_W       10
`define CAP_CH_W        2
`define CAP_ADDR_W      (`CAP_CH_W + 1 + `CAP_OFS_W)

`endif

// File: hw/capture_pkg.sv
`default_nettype none

`include "capture_macros.svh"

package capture_pkg;

    // one memory data word
    typedef logic [`CAP_WORD_W-1:0] word_t;

    // one camera sample as seen on the sensor pins
    typedef struct packed {
        logic                   valid;
        logic                   vsync;
        logic [`CAP_BYTE_W-1:0] data;
    } cam_beat_t;

    // burst request from a channel slave
    typedef struct packed {
        logic                  bank;
        logic [`CAP_OFS_W-1:0] ofs;
    } burst_cmd_t;

    // granted burst handed to the write engine
    typedef struct packed {
        logic [`CAP_CH_W-1:0]  ch;
        logic                  bank;
        logic [`CAP_OFS_W-1:0] ofs;
    } mem_cmd_t;

    // one beat on the memory write port
    typedef struct packed {
        logic [`CAP_ADDR_W-1:0] addr;
        word_t                  data;
        logic                   last;
    } mem_wr_t;

endpackage

`default_nettype wire

// File: hw/pixel_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module pixel_packer
    import capture_pkg::*;
(
    input  logic      ddr_clk,
    input  logic      rst_n,
    input  cam_beat_t cam,
    output logic      push,
    output word_t     push_word,
    output logic      frame_start
);

    // byte slot of the next accepted byte
    logic [1:0] byte_cnt;
    // vsync one cycle late
    logic       vsync_q;
    // newest byte enters at the top
    word_t      shift_q;
    logic       vsync_rise;

    assign vsync_rise = cam.vsync & ~vsync_q;

    // --------------------------------------------------
    // byte counting and frame edge
    always_ff @(posedge ddr_clk) begin
        if (!rst_n) begin
            byte_cnt    <= '0;
            vsync_q     <= 1'b0;
            push        <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            vsync_q     <= cam.vsync;
            frame_start <= vsync_rise;
            push        <= 1'b0;
            if (vsync_rise) begin
                // partial word of the old frame is dropped
                byte_cnt <= '0;
            end else if (cam.valid) begin
                byte_cnt <= byte_cnt + 2'd1;
                // fourth byte closes the word
                if (byte_cnt == 2'd3) begin
                    push <= 1'b1;
                end
            end
        end
    end

    // little endian packing
    // after four shifts the first byte sits in bits 7:0
    always_ff @(posedge ddr_clk) begin
        if (cam.valid) begin
            shift_q <= {cam.data, shift_q[`CAP_WORD_W-1:`CAP_BYTE_W]};
        end
    end

    // fifo samples this before the next byte shifts in
    assign push_word = shift_q;

endmodule

`default_nettype wire

// File: hw/word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module word_fifo
    import capture_pkg::*;
(
    input  logic                  ddr_clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  push,
    input  word_t                 push_word,
    input  logic                  pop,
    output word_t                 head,
    output logic [`CAP_CNT_W-1:0] count
);

    localparam int PTR_W = $clog2(`CAP_FIFO_DEPTH);

    word_t            mem [`CAP_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // writes into a full buffer are lost
    assign full  = (count == `CAP_CNT_W'(`CAP_FIFO_DEPTH));
    assign wr_en = push & ~full;
    assign rd_en = pop & (count != '0);

    // --------------------------------------------------
    // pointers and fill level
    always_ff @(posedge ddr_clk) begin
        if (!rst_n || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count + `CAP_CNT_W'(wr_en) - `CAP_CNT_W'(rd_en);
        end
    end

    // storage
    always_ff @(posedge ddr_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // show ahead read
    assign head = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/channel_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module channel_slave
    import capture_pkg::*;
(
    input  logic                  ddr_clk,
    input  logic                  rst_n,
    input  logic                  frame_start,
    input  logic [`CAP_CNT_W-1:0] count,
    input  logic                  grant,
    output logic                  req,
    output burst_cmd_t            cmd
);

    logic full_burst;

    // enough words queued for one burst
    assign full_burst = (count >= `CAP_CNT_W'(`CAP_BURST_LEN));

    // --------------------------------------------------
    // request and write pointer
    // grant stays high until the engine reports done
    // so while it is high our own burst is still outstanding
    // and the fill count still holds words already claimed
    always_ff @(posedge ddr_clk) begin
        if (!rst_n) begin
            req      <= 1'b0;
            cmd.bank <= 1'b0;
            cmd.ofs  <= '0;
        end else if (frame_start) begin
            // switch to the other buffer
            cmd.bank <= ~cmd.bank;
            cmd.ofs  <= '0;
            req      <= 1'b0;
        end else if (grant) begin
            // first grant cycle retires the request
            if (req) begin
                req     <= 1'b0;
                cmd.ofs <= cmd.ofs + `CAP_OFS_W'(`CAP_BURST_LEN);
            end
        end else if (full_burst) begin
            // held until granted
            req <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/burst_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module burst_arbiter
    import capture_pkg::*;
(
    input  logic                   ddr_clk,
    input  logic                   rst_n,
    input  logic [`CAP_NUM_CH-1:0] req,
    input  burst_cmd_t             cmd [`CAP_NUM_CH],
    input  word_t                  head [`CAP_NUM_CH],
    output logic [`CAP_NUM_CH-1:0] grant,
    output logic [`CAP_NUM_CH-1:0] pop_ch,
    output logic                   start,
    output mem_cmd_t               mcmd,
    input  logic                   pop,
    output word_t                  word,
    input  logic                   done
);

    logic                 busy;
    // last granted channel and also the current owner while busy
    logic [`CAP_CH_W-1:0] last_ch;
    logic [`CAP_CH_W-1:0] pick;
    logic                 found;

    // --------------------------------------------------
    // round robin search starting after the last grant
    always_comb begin
        int unsigned idx;
        pick  = last_ch;
        found = 1'b0;
        for (int k = 1; k <= `CAP_NUM_CH; k++) begin
            idx = (int'(last_ch) + k) % `CAP_NUM_CH;
            if (!found && req[idx]) begin
                pick  = `CAP_CH_W'(idx);
                found = 1'b1;
            end
        end
    end

    // one burst at a time
    always_ff @(posedge ddr_clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            start   <= 1'b0;
            // channel 0 wins first
            last_ch <= `CAP_CH_W'(`CAP_NUM_CH - 1);
        end else begin
            start <= 1'b0;
            if (busy) begin
                if (done) begin
                    busy <= 1'b0;
                end
            end else if (found) begin
                busy    <= 1'b1;
                start   <= 1'b1;
                last_ch <= pick;
            end
        end
    end

    // winner command tagged with its channel
    always_ff @(posedge ddr_clk) begin
        if (!busy && found) begin
            mcmd.ch   <= pick;
            mcmd.bank <= cmd[pick].bank;
            mcmd.ofs  <= cmd[pick].ofs;
        end
    end

    // --------------------------------------------------
    // data path to and from the owner fifo
    always_comb begin
        for (int i = 0; i < `CAP_NUM_CH; i++) begin
            grant[i]  = busy && (last_ch == `CAP_CH_W'(i));
            pop_ch[i] = grant[i] && pop;
        end
    end

    assign word = head[last_ch];

endmodule

`default_nettype wire

// File: hw/mem_write_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module mem_write_engine
    import capture_pkg::*;
(
    input  logic     ddr_clk,
    input  logic     rst_n,
    input  logic     start,
    input  mem_cmd_t mcmd,
    input  word_t    word,
    output logic     pop,
    output logic     done,
    output mem_wr_t  mem_wr,
    output logic     mem_wr_valid,
    input  logic     mem_wr_ready
);

    localparam int BEAT_W = $clog2(`CAP_BURST_LEN);

    logic [BEAT_W-1:0]      beat;
    logic [`CAP_ADDR_W-1:0] addr;
    logic                   accept;
    logic                   last_beat;

    assign accept    = mem_wr_valid & mem_wr_ready;
    assign last_beat = (beat == BEAT_W'(`CAP_BURST_LEN - 1));

    // --------------------------------------------------
    // beat sequencing
    always_ff @(posedge ddr_clk) begin
        if (!rst_n) begin
            mem_wr_valid <= 1'b0;
            done         <= 1'b0;
            beat         <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                mem_wr_valid <= 1'b1;
                beat         <= '0;
            end else if (accept) begin
                beat <= beat + BEAT_W'(1);
                if (last_beat) begin
                    mem_wr_valid <= 1'b0;
                    done         <= 1'b1;
                end
            end
        end
    end

    // address moves only on an accepted beat
    // carry stays inside the offset field
    always_ff @(posedge ddr_clk) begin
        if (start) begin
            addr <= {mcmd.ch, mcmd.bank, mcmd.ofs};
        end else if (accept) begin
            addr <= {addr[`CAP_ADDR_W-1:`CAP_OFS_W], addr[`CAP_OFS_W-1:0] + `CAP_OFS_W'(1)};
        end
    end

    // head word is held while stalled since nothing pops
    assign pop    = accept;
    assign mem_wr = '{addr: addr, data: word, last: last_beat};

endmodule

`default_nettype wire

// File: hw/capture_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module capture_top
    import capture_pkg::*;
(
    input  logic      ddr_clk,
    input  logic      rst_n,
    input  cam_beat_t cam [`CAP_NUM_CH],
    output mem_wr_t   mem_wr,
    output logic      mem_wr_valid,
    input  logic      mem_wr_ready
);

    // --------------------------------------------------
    // per lane wiring
    logic [`CAP_NUM_CH-1:0] push;
    logic [`CAP_NUM_CH-1:0] frame_start;
    logic [`CAP_NUM_CH-1:0] req;
    logic [`CAP_NUM_CH-1:0] grant;
    logic [`CAP_NUM_CH-1:0] pop_ch;
    word_t                  push_word [`CAP_NUM_CH];
    word_t                  head [`CAP_NUM_CH];
    logic [`CAP_CNT_W-1:0]  count [`CAP_NUM_CH];
    burst_cmd_t             cmd [`CAP_NUM_CH];

    // arbiter to engine
    logic                   start;
    logic                   pop;
    logic                   done;
    mem_cmd_t               mcmd;
    word_t                  word;

    // camera lanes
    for (genvar i = 0; i < `CAP_NUM_CH; i++) begin : g_lane
        pixel_packer u_packer (
            .ddr_clk     (ddr_clk),
            .rst_n       (rst_n),
            .cam         (cam[i]),
            .push        (push[i]),
            .push_word   (push_word[i]),
            .frame_start (frame_start[i])
        );

        // new frame flushes the queue
        word_fifo u_fifo (
            .ddr_clk   (ddr_clk),
            .rst_n     (rst_n),
            .clear     (frame_start[i]),
            .push      (push[i]),
            .push_word (push_word[i]),
            .pop       (pop_ch[i]),
            .head      (head[i]),
            .count     (count[i])
        );

        channel_slave u_slave (
            .ddr_clk     (ddr_clk),
            .rst_n       (rst_n),
            .frame_start (frame_start[i]),
            .count       (count[i]),
            .grant       (grant[i]),
            .req         (req[i]),
            .cmd         (cmd[i])
        );
    end

    // --------------------------------------------------
    // shared write side
    burst_arbiter u_arb (
        .ddr_clk (ddr_clk),
        .rst_n   (rst_n),
        .req     (req),
        .cmd     (cmd),
        .head    (head),
        .grant   (grant),
        .pop_ch  (pop_ch),
        .start   (start),
        .mcmd    (mcmd),
        .pop     (pop),
        .word    (word),
        .done    (done)
    );

    mem_write_engine u_eng (
        .ddr_clk      (ddr_clk),
        .rst_n        (rst_n),
        .start        (start),
        .mcmd         (mcmd),
        .word         (word),
        .pop          (pop),
        .done         (done),
        .mem_wr       (mem_wr),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready)
    );

endmodule

`default_nettype wire

// File: dv/capture_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module capture_sva
    import capture_pkg::*;
(
    input logic    ddr_clk,
    input logic    rst_n,
    input mem_wr_t mem_wr,
    input logic    mem_wr_valid,
    input logic    mem_wr_ready
);

    localparam int BEAT_W = $clog2(`CAP_BURST_LEN);

    // number of failed assertions
    int unsigned       fail_cnt = 0;
    logic [BEAT_W-1:0] beat_cnt;
    logic              accept;

    assign accept = mem_wr_valid & mem_wr_ready;

    // --------------------------------------------------
    // accepted beats within the current burst
    always_ff @(posedge ddr_clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (accept) begin
            beat_cnt <= beat_cnt + BEAT_W'(1);
        end
    end

    // stalled beat stays put
    hold_stable: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        mem_wr_valid && !mem_wr_ready |=> mem_wr_valid && $stable(mem_wr))
    else begin
        fail_cnt++;
        $error("memory write beat changed while stalled");
    end

    // last only on every eighth accepted beat
    last_spacing: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        accept |-> (mem_wr.last == (beat_cnt == BEAT_W'(`CAP_BURST_LEN - 1))))
    else begin
        fail_cnt++;
        $error("last flag out of place within a burst");
    end

    // nothing valid while in reset
    reset_idle: assert property (@(posedge ddr_clk) !rst_n |=> !mem_wr_valid)
    else begin
        fail_cnt++;
        $error("memory write valid high during reset");
    end

endmodule

bind capture_top capture_sva u_sva (
    .ddr_clk      (ddr_clk),
    .rst_n        (rst_n),
    .mem_wr       (mem_wr),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_ready (mem_wr_ready)
);

`default_nettype wire

// File: dv/capture_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "capture_macros.svh"

module capture_tb
    import capture_pkg::*;
();

    localparam int SEED        = 98098;
    localparam int SEND_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 5000;
    localparam int N_ROWS      = 6;

    // one frame per row on every channel in mask
    typedef struct packed {
        logic [`CAP_NUM_CH-1:0] mask;
        int                     words;
        int                     trail;
        int                     duty;
    } row_t;

    // expected beat as the scoreboard keeps it
    typedef struct packed {
        logic [`CAP_ADDR_W-1:0] addr;
        word_t                  data;
    } beat_t;

    // mask, frame words, trailing bytes, ready duty in percent
    localparam row_t ROWS [N_ROWS] = '{
        '{3'b001, 16, 0, 100},
        '{3'b001, 8, 5, 100},
        // all channels compete for the engine
        '{3'b111, 24, 3, 80},
        '{3'b111, 32, 13, 30},
        // seven stray words plus two bytes
        '{3'b010, 16, 30, 60},
        '{3'b101, 16, 0, 50}
    };

    logic      ddr_clk = 1'b0;
    logic      rst_n;
    cam_beat_t cam [`CAP_NUM_CH];
    mem_wr_t   mem_wr;
    logic      mem_wr_valid;
    logic      mem_wr_ready;

    // --------------------------------------------------
    // scoreboard state
    beat_t                 exp_q [`CAP_NUM_CH][$];
    logic                  bank [`CAP_NUM_CH];
    logic [`CAP_OFS_W-1:0] ofs [`CAP_NUM_CH];
    int                    duty;
    int                    errors;
    int                    beats;
    int                    burst_pos;
    logic [`CAP_CH_W-1:0]  burst_ch;
    // empty while no wait has run out
    string                 timeout_msg;

    always #2 ddr_clk = ~ddr_clk;

    capture_top u_dut (
        .ddr_clk      (ddr_clk),
        .rst_n        (rst_n),
        .cam          (cam),
        .mem_wr       (mem_wr),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready)
    );

    // one clock with a fresh ready draw on the falling edge
    task automatic step();
        @(negedge ddr_clk);
        mem_wr_ready = ($urandom_range(99) < duty);
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int c = 0; c < `CAP_NUM_CH; c++) begin
            n += exp_q[c].size();
        end
        return n;
    endfunction

    task automatic end_run(input bit timed_out, input string what);
        int sva_errs;
        sva_errs = u_dut.u_sva.fail_cnt;
        if (timed_out) begin
            $display("timeout: %s", what);
        end
        $display("beats %0d, scoreboard errors %0d, assertion failures %0d",
                 beats, errors, sva_errs);
        if (!timed_out && errors == 0 && sva_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // one frame as vsync pulse, bytes, then drain
    task automatic run_frame(input row_t row);
        int         sent [`CAP_NUM_CH];
        word_t      cur [`CAP_NUM_CH];
        logic [7:0] b;
        int         cyc;
        bit         sending;
        duty = row.duty;
        step();
        for (int c = 0; c < `CAP_NUM_CH; c++) begin
            sent[c] = 0;
            if (row.mask[c]) begin
                cam[c].vsync = 1'b1;
                bank[c]      = ~bank[c];
                ofs[c]       = '0;
            end
        end
        step();
        for (int c = 0; c < `CAP_NUM_CH; c++) begin
            cam[c].vsync = 1'b0;
        end
        repeat (2) step();
        cyc     = 0;
        sending = 1'b1;
        while (sending && cyc < SEND_LIMIT) begin
            step();
            cyc++;
            sending = 1'b0;
            for (int c = 0; c < `CAP_NUM_CH; c++) begin
                cam[c].valid = 1'b0;
                if (row.mask[c] && sent[c] < 4 * row.words + row.trail) begin
                    sending = 1'b1;
                    // about one byte in four cycles keeps the fifos shallow
                    if ($urandom_range(3) == 0) begin
                        b            = 8'($urandom);
                        cam[c].valid = 1'b1;
                        cam[c].data  = b;
                        cur[c][8 * (sent[c] % 4) +: 8] = b;
                        sent[c]++;
                        // trailing bytes never reach memory
                        if (sent[c] % 4 == 0 && sent[c] <= 4 * row.words) begin
                            exp_q[c].push_back(beat_t'{addr: {`CAP_CH_W'(c), bank[c], ofs[c]},
                                                       data: cur[c]});
                            ofs[c]++;
                        end
                    end
                end
            end
        end
        if (sending) begin
            timeout_msg = "camera bytes not all sent";
        end else begin
            cyc = 0;
            while (pending() != 0 && cyc < DRAIN_LIMIT) begin
                step();
                cyc++;
            end
            if (pending() != 0) begin
                timeout_msg = "memory writes of a frame never arrived";
            end else begin
                // done and grant release settle before the next vsync
                repeat (8) step();
            end
        end
    endtask

    // --------------------------------------------------
    // monitor on the memory write port
    always @(posedge ddr_clk) begin
        logic [`CAP_CH_W-1:0] ch;
        beat_t                want;
        if (rst_n && mem_wr_valid && mem_wr_ready) begin
            ch = mem_wr.addr[`CAP_ADDR_W-1 -: `CAP_CH_W];
            beats++;
            assert (ch < `CAP_NUM_CH && exp_q[ch].size() > 0) else begin
                errors++;
                $display("unexpected write beat at %0t ns to address %h", $time, mem_wr.addr);
            end
            if (ch < `CAP_NUM_CH && exp_q[ch].size() > 0) begin
                want = exp_q[ch].pop_front();
                assert (mem_wr.addr == want.addr) else begin
                    errors++;
                    $display("[FAIL] %0t ns mem_wr.addr got %h exp %h",
                             $time, mem_wr.addr, want.addr);
                end
                assert (mem_wr.data == want.data) else begin
                    errors++;
                    $display("[FAIL] %0t ns mem_wr.data got %h exp %h",
                             $time, mem_wr.data, want.data);
                end
            end
            // a burst never mixes channels
            if (burst_pos == 0) begin
                burst_ch = ch;
            end
            assert (ch == burst_ch) else begin
                errors++;
                $display("[FAIL] %0t ns mem_wr.addr channel got %0d exp %0d",
                         $time, ch, burst_ch);
            end
            assert (mem_wr.last == (burst_pos == `CAP_BURST_LEN - 1)) else begin
                errors++;
                $display("[FAIL] %0t ns mem_wr.last got %b exp %b",
                         $time, mem_wr.last, burst_pos == `CAP_BURST_LEN - 1);
            end
            burst_pos = (burst_pos + 1) % `CAP_BURST_LEN;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        mem_wr_ready = 1'b0;
        duty         = 100;
        errors       = 0;
        beats        = 0;
        burst_pos    = 0;
        burst_ch     = '0;
        timeout_msg  = "";
        for (int c = 0; c < `CAP_NUM_CH; c++) begin
            cam[c]  = '0;
            bank[c] = 1'b0;
            ofs[c]  = '0;
        end
        repeat (3) @(negedge ddr_clk);
        rst_n = 1'b1;
        for (int r = 0; r < N_ROWS && timeout_msg == ""; r++) begin
            run_frame(ROWS[r]);
        end
        if (timeout_msg == "") begin
            // stray beats after the last frame would show up here
            repeat (50) step();
        end
        end_run(timeout_msg != "", timeout_msg);
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/capture_pkg.sv
hw/pixel_packer.sv
hw/word_fifo.sv
hw/channel_slave.sv
hw/burst_arbiter.sv
hw/mem_write_engine.sv
hw/capture_top.sv
dv/capture_sva.sv
dv/capture_tb.sv

// File: Bender.yml
package:
  name: capture

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/capture_pkg.sv
      - hw/pixel_packer.sv
      - hw/word_fifo.sv
      - hw/channel_slave.sv
      - hw/burst_arbiter.sv
      - hw/mem_write_engine.sv
      - hw/capture_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/capture_sva.sv
      - dv/capture_tb.sv
